/* source/fixdiv_pkg.sv */
package fixdiv_pkg;

    // Core FSM of the iterative divider
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ITERATE = 2'd1,
        DONE    = 2'd2
    } div_state_e;

    // Sign and zero sideband, prep to core to fix-up
    typedef struct packed {
        logic negate_quotient;  // Operand signs differ
        logic negate_remainder; // Dividend negative
        logic div_by_zero;      // Divisor zero
    } div_sign_t;

    // Result status flags
    typedef struct packed {
        logic div_by_zero;
        logic overflow;         // Quotient clamped
    } div_status_t;

    parameter int DEFAULT_DATA_WIDTH     = 16;
    parameter int DEFAULT_QUANTIZED_BITS = 8;

endpackage

/* source/div_operand_prep.sv */
`timescale 1ns/1ps

module div_operand_prep #(
    parameter int DATA_WIDTH     = fixdiv_pkg::DEFAULT_DATA_WIDTH,
    parameter int QUANTIZED_BITS = fixdiv_pkg::DEFAULT_QUANTIZED_BITS
)(
    input  logic                                         clock,
    input  logic                                         reset,
    input  logic                                         valid_in,
    input  logic signed [DATA_WIDTH-1:0]                 dividend,
    input  logic signed [DATA_WIDTH-1:0]                 divisor,
    input  logic                                         core_busy,
    output logic                                         start,
    output logic        [DATA_WIDTH+QUANTIZED_BITS-1:0] dividend_mag,
    output logic        [DATA_WIDTH+QUANTIZED_BITS-1:0] divisor_mag,
    output fixdiv_pkg::div_sign_t                        sign_info,
    output logic                                         prep_pending
);

    import fixdiv_pkg::*;

    logic signed [DATA_WIDTH:0] dividend_wide;
    logic signed [DATA_WIDTH:0] divisor_wide;
    logic        [DATA_WIDTH:0] dividend_abs;
    logic        [DATA_WIDTH:0] divisor_abs;
    logic                       accept;
    div_sign_t                  sign_c;

    // One extra bit so the most negative input has a magnitude
    assign dividend_wide = dividend;
    assign divisor_wide  = divisor;
    assign dividend_abs  = dividend_wide[DATA_WIDTH] ? -dividend_wide : dividend_wide;
    assign divisor_abs   = divisor_wide[DATA_WIDTH] ? -divisor_wide : divisor_wide;

    assign accept = valid_in && !core_busy && !start; // Dropped while busy

    always_comb begin
        sign_c.negate_quotient  = dividend[DATA_WIDTH-1] ^ divisor[DATA_WIDTH-1];
        sign_c.negate_remainder = dividend[DATA_WIDTH-1];
        sign_c.div_by_zero      = (divisor == '0);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            start <= 1'b0;
        end else begin
            start <= accept; // Single cycle strobe to core
        end
    end

    // Held until the next request as the core copies on start
    always_ff @(posedge clock) begin
        if (accept) begin
            dividend_mag <= {dividend_abs[DATA_WIDTH-1:0], {QUANTIZED_BITS{1'b0}}};
            divisor_mag  <= {{QUANTIZED_BITS{1'b0}}, divisor_abs[DATA_WIDTH-1:0]};
            sign_info    <= sign_c;
        end
    end

    assign prep_pending = start;

    // Caller must wait for busy to drop before the next request
    a_no_request_while_busy: assert property (
        @(posedge clock) disable iff (reset)
        valid_in |-> !(core_busy || prep_pending)
    ) else $error("valid_in raised while the unit is busy");

endmodule

/* source/nonrestoring_divider.sv */
`timescale 1ns/1ps

module nonrestoring_divider #(
    parameter int WIDTH = fixdiv_pkg::DEFAULT_DATA_WIDTH + fixdiv_pkg::DEFAULT_QUANTIZED_BITS
)(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic [WIDTH-1:0]      dividend_mag,
    input  logic [WIDTH-1:0]      divisor_mag,
    input  fixdiv_pkg::div_sign_t sign_info_in,
    output logic                  done,
    output logic [WIDTH-1:0]      quotient_mag,
    output logic [WIDTH-1:0]      remainder_mag,
    output fixdiv_pkg::div_sign_t sign_info_out,
    output logic                  core_busy
);

    import fixdiv_pkg::*;

    localparam int COUNT_WIDTH = $clog2(WIDTH + 1);

    div_state_e             state, state_c;
    logic [COUNT_WIDTH-1:0] count, count_c;
    logic [2*WIDTH:0]       aq, aq_c;           // Accumulator above quotient
    logic [WIDTH-1:0]       divisor_r, divisor_c;
    div_sign_t              sign_r, sign_c;
    logic [2*WIDTH:0]       aq_shift;
    logic [WIDTH:0]         acc_step;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            count <= '0;
        end else begin
            state <= state_c;
            count <= count_c;
        end
    end

    always_ff @(posedge clock) begin
        aq        <= aq_c;
        divisor_r <= divisor_c;
        sign_r    <= sign_c;
    end

    always_comb begin
        state_c   = state;
        count_c   = count;
        aq_c      = aq;
        divisor_c = divisor_r;
        sign_c    = sign_r;
        aq_shift  = aq << 1;
        acc_step  = '0;

        case (state)
            IDLE: begin
                if (start) begin
                    aq_c      = {{(WIDTH+1){1'b0}}, dividend_mag};
                    divisor_c = divisor_mag;
                    sign_c    = sign_info_in;
                    count_c   = '0;
                    state_c   = ITERATE;
                end
            end

            ITERATE: begin
                // Add or subtract chosen by sign of the old accumulator
                if (aq[2*WIDTH]) begin
                    acc_step = aq_shift[2*WIDTH:WIDTH] + {1'b0, divisor_r};
                end else begin
                    acc_step = aq_shift[2*WIDTH:WIDTH] - {1'b0, divisor_r};
                end
                aq_c    = {acc_step, aq_shift[WIDTH-1:1], ~acc_step[WIDTH]};
                count_c = count + 1'b1;

                if (count_c == WIDTH) begin
                    if (aq_c[2*WIDTH]) begin
                        aq_c[2*WIDTH:WIDTH] = aq_c[2*WIDTH:WIDTH] + {1'b0, divisor_r}; // Add back
                    end
                    state_c = DONE;
                end
            end

            DONE: begin
                state_c = IDLE; // Results shown for one cycle
            end

            default: begin
                state_c = IDLE;
            end
        endcase
    end

    assign done          = (state == DONE);
    assign core_busy     = (state != IDLE);
    assign quotient_mag  = aq[WIDTH-1:0];
    assign remainder_mag = aq[2*WIDTH-1:WIDTH];
    assign sign_info_out = sign_r;

    a_start_in_idle: assert property (
        @(posedge clock) disable iff (reset)
        start |-> (state == IDLE)
    ) else $error("start received while core is %s", state.name());

    a_done_single: assert property (
        @(posedge clock) disable iff (reset)
        done |=> !done
    ) else $error("done held longer than one cycle");

    a_count_bound: assert property (
        @(posedge clock) disable iff (reset)
        count <= WIDTH
    ) else $error("iteration counter ran past %0d", WIDTH);

endmodule

/* source/div_result_fixup.sv */
`timescale 1ns/1ps

module div_result_fixup #(
    parameter int DATA_WIDTH     = fixdiv_pkg::DEFAULT_DATA_WIDTH,
    parameter int QUANTIZED_BITS = fixdiv_pkg::DEFAULT_QUANTIZED_BITS
)(
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  done,
    input  logic [DATA_WIDTH+QUANTIZED_BITS-1:0]  quotient_mag,
    input  logic [DATA_WIDTH+QUANTIZED_BITS-1:0]  remainder_mag,
    input  fixdiv_pkg::div_sign_t                 sign_info,
    output logic                                  valid_out,
    output logic signed [DATA_WIDTH-1:0]          quotient,
    output logic signed [DATA_WIDTH-1:0]          remainder,
    output fixdiv_pkg::div_status_t               status
);

    import fixdiv_pkg::*;

    localparam int CORE_WIDTH = DATA_WIDTH + QUANTIZED_BITS;

    // Signed limits of the output, extended to the core width
    localparam logic signed [CORE_WIDTH:0] Q_MAX =
        {{(QUANTIZED_BITS+2){1'b0}}, {(DATA_WIDTH-1){1'b1}}};
    localparam logic signed [CORE_WIDTH:0] Q_MIN =
        {{(QUANTIZED_BITS+2){1'b1}}, {(DATA_WIDTH-1){1'b0}}};

    logic signed [CORE_WIDTH:0]   quotient_wide;
    logic signed [CORE_WIDTH:0]   remainder_wide;
    logic signed [DATA_WIDTH-1:0] quotient_c;
    logic signed [DATA_WIDTH-1:0] remainder_c;
    div_status_t                  status_c;

    always_comb begin
        quotient_wide  = sign_info.negate_quotient ? -signed'({1'b0, quotient_mag})
                                                   : signed'({1'b0, quotient_mag});
        remainder_wide = sign_info.negate_remainder ? -signed'({1'b0, remainder_mag})
                                                    : signed'({1'b0, remainder_mag});
        status_c    = '0;
        remainder_c = remainder_wide[DATA_WIDTH-1:0]; // Below divisor, so exact

        if (sign_info.div_by_zero) begin
            quotient_c = sign_info.negate_remainder ? Q_MIN[DATA_WIDTH-1:0]
                                                    : Q_MAX[DATA_WIDTH-1:0];
            remainder_c          = '0;
            status_c.div_by_zero = 1'b1;
        end else if (quotient_wide > Q_MAX) begin
            quotient_c        = Q_MAX[DATA_WIDTH-1:0];
            status_c.overflow = 1'b1;
        end else if (quotient_wide < Q_MIN) begin
            quotient_c        = Q_MIN[DATA_WIDTH-1:0];
            status_c.overflow = 1'b1;
        end else begin
            quotient_c = quotient_wide[DATA_WIDTH-1:0];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_out <= 1'b0;
            quotient  <= '0;
            remainder <= '0;
            status    <= '0;
        end else begin
            valid_out <= done;
            if (done) begin // Held until the next result
                quotient  <= quotient_c;
                remainder <= remainder_c;
                status    <= status_c;
            end
        end
    end

    // Core needs more than one cycle per division
    a_valid_out_pulse: assert property (
        @(posedge clock) disable iff (reset)
        valid_out |=> !valid_out
    ) else $error("valid_out high on consecutive cycles");

endmodule

/* source/fixdiv_top.sv */
`timescale 1ns/1ps

module fixdiv_top #(
    parameter int DATA_WIDTH     = fixdiv_pkg::DEFAULT_DATA_WIDTH,
    parameter int QUANTIZED_BITS = fixdiv_pkg::DEFAULT_QUANTIZED_BITS
)(
    input  logic                         clock,
    input  logic                         reset,
    input  logic signed [DATA_WIDTH-1:0] dividend,
    input  logic signed [DATA_WIDTH-1:0] divisor,
    input  logic                         valid_in,
    output logic signed [DATA_WIDTH-1:0] quotient,
    output logic signed [DATA_WIDTH-1:0] remainder,
    output fixdiv_pkg::div_status_t      status,
    output logic                         valid_out,
    output logic                         busy
);

    import fixdiv_pkg::*;

    localparam int CORE_WIDTH = DATA_WIDTH + QUANTIZED_BITS;

    logic                  start;
    logic                  done;
    logic                  prep_pending;
    logic                  core_busy;
    logic [CORE_WIDTH-1:0] dividend_mag;
    logic [CORE_WIDTH-1:0] divisor_mag;
    logic [CORE_WIDTH-1:0] quotient_mag;
    logic [CORE_WIDTH-1:0] remainder_mag;
    div_sign_t             prep_sign;
    div_sign_t             core_sign;

    div_operand_prep #(
        .DATA_WIDTH     (DATA_WIDTH),
        .QUANTIZED_BITS (QUANTIZED_BITS)
    ) u_prep (
        .clock        (clock),
        .reset        (reset),
        .valid_in     (valid_in),
        .dividend     (dividend),
        .divisor      (divisor),
        .core_busy    (core_busy),
        .start        (start),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .sign_info    (prep_sign),
        .prep_pending (prep_pending)
    );

    nonrestoring_divider #(
        .WIDTH (CORE_WIDTH)
    ) u_core (
        .clock         (clock),
        .reset         (reset),
        .start         (start),
        .dividend_mag  (dividend_mag),
        .divisor_mag   (divisor_mag),
        .sign_info_in  (prep_sign),
        .done          (done),
        .quotient_mag  (quotient_mag),
        .remainder_mag (remainder_mag),
        .sign_info_out (core_sign),
        .core_busy     (core_busy)
    );

    div_result_fixup #(
        .DATA_WIDTH     (DATA_WIDTH),
        .QUANTIZED_BITS (QUANTIZED_BITS)
    ) u_fixup (
        .clock         (clock),
        .reset         (reset),
        .done          (done),
        .quotient_mag  (quotient_mag),
        .remainder_mag (remainder_mag),
        .sign_info     (core_sign),
        .valid_out     (valid_out),
        .quotient      (quotient),
        .remainder     (remainder),
        .status        (status)
    );

    assign busy = prep_pending | core_busy; // One division at a time

endmodule

/* tb/fixdiv_tb.sv */
`timescale 1ns/1ps

module fixdiv_tb;

    import fixdiv_pkg::*;

    localparam int DATA_WIDTH     = DEFAULT_DATA_WIDTH;
    localparam int QUANTIZED_BITS = DEFAULT_QUANTIZED_BITS;
    localparam int LATENCY        = DATA_WIDTH + QUANTIZED_BITS + 3; // valid_in to valid_out
    localparam int CLOCK_PERIOD   = 8;
    localparam int NUM_RANDOM     = 200;
    localparam int NUM_REQUESTS   = 8 + 3 + 5 + NUM_RANDOM;
    localparam int TIMEOUT_NS     = (NUM_REQUESTS * LATENCY * 5 / 4 + 100) * CLOCK_PERIOD;

    localparam longint Q_MAX = (longint'(1) << (DATA_WIDTH - 1)) - 1;
    localparam longint Q_MIN = -(longint'(1) << (DATA_WIDTH - 1));

    logic                         clock;
    logic                         reset;
    logic signed [DATA_WIDTH-1:0] dividend;
    logic signed [DATA_WIDTH-1:0] divisor;
    logic                         valid_in;
    logic signed [DATA_WIDTH-1:0] quotient;
    logic signed [DATA_WIDTH-1:0] remainder;
    div_status_t                  status;
    logic                         valid_out;
    logic                         busy;

    logic signed [DATA_WIDTH-1:0] exp_quotient;
    logic signed [DATA_WIDTH-1:0] exp_remainder;
    div_status_t                  exp_status;
    logic                         outstanding;  // Request accepted, result not yet seen
    div_state_e                   core_state;
    string                        test_name;
    int                           fail_count;
    int                           fails_at_start;
    int                           tests_passed;
    int                           tests_failed;
    integer                       seed;

    fixdiv_top #(
        .DATA_WIDTH     (DATA_WIDTH),
        .QUANTIZED_BITS (QUANTIZED_BITS)
    ) u_dut (
        .clock     (clock),
        .reset     (reset),
        .dividend  (dividend),
        .divisor   (divisor),
        .valid_in  (valid_in),
        .quotient  (quotient),
        .remainder (remainder),
        .status    (status),
        .valid_out (valid_out),
        .busy      (busy)
    );

    assign core_state = u_dut.u_core.state;

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (valid_in) begin
            outstanding <= 1'b1;
        end else if (valid_out) begin
            outstanding <= 1'b0;
        end
    end

    // Outputs cleared during reset and on the first edge after it
    a_reset_values: assert property (@(posedge clock)
        $past(reset) |-> !valid_out && !busy && status == '0 && quotient == '0 &&
                         remainder == '0
    ) else begin
        fail_count++;
        $display(
            "FAILED %s: expected zeros, actual valid_out=%b busy=%b status=%b q=%0d r=%0d",
            test_name, valid_out, busy, status, quotient, remainder);
    end

    a_latency: assert property (@(posedge clock) disable iff (reset)
        valid_out == $past(valid_in, LATENCY)
    ) else begin
        fail_count++;
        $display("FAILED %s: valid_out did not come exactly %0d cycles after valid_in",
                 test_name, LATENCY);
    end

    a_busy_level: assert property (@(posedge clock) disable iff (reset)
        busy == (outstanding && !valid_out)
    ) else begin
        fail_count++;
        $display("FAILED %s: busy expected %b, actual %b", test_name,
                 outstanding && !valid_out, busy);
    end

    a_quotient: assert property (@(posedge clock) disable iff (reset)
        valid_out |-> quotient == exp_quotient
    ) else begin
        fail_count++;
        $display("FAILED %s: quotient expected %0d, actual %0d", test_name, exp_quotient,
                 quotient);
    end

    a_remainder: assert property (@(posedge clock) disable iff (reset)
        valid_out |-> remainder == exp_remainder
    ) else begin
        fail_count++;
        $display("FAILED %s: remainder expected %0d, actual %0d", test_name, exp_remainder,
                 remainder);
    end

    a_status: assert property (@(posedge clock) disable iff (reset)
        valid_out |-> status == exp_status
    ) else begin
        fail_count++;
        $display("FAILED %s: status expected %b, actual %b", test_name, exp_status, status);
    end

    a_outputs_held: assert property (@(posedge clock) disable iff (reset)
        !valid_out |-> $stable(quotient) && $stable(remainder) && $stable(status)
    ) else begin
        fail_count++;
        $display("FAILED %s: outputs changed between valid_out pulses", test_name);
    end

    // Scaled division, truncated toward zero, then the saturation rules
    task automatic predict_result(input logic signed [DATA_WIDTH-1:0] a,
                                  input logic signed [DATA_WIDTH-1:0] b);
        longint scaled;
        longint q;
        longint r;
        scaled     = longint'(a) <<< QUANTIZED_BITS;
        exp_status = '0;
        if (b == '0) begin
            q                      = (a < 0) ? Q_MIN : Q_MAX;
            r                      = 0;
            exp_status.div_by_zero = 1'b1;
        end else begin
            q = scaled / longint'(b);
            r = scaled % longint'(b); // Sign follows the dividend
            if (q > Q_MAX) begin
                q                   = Q_MAX;
                exp_status.overflow = 1'b1;
            end else if (q < Q_MIN) begin
                q                   = Q_MIN;
                exp_status.overflow = 1'b1;
            end
        end
        exp_quotient  = q[DATA_WIDTH-1:0];
        exp_remainder = r[DATA_WIDTH-1:0];
    endtask

    // Entered 1 ns after an edge and left 1 ns after the checking edge
    task automatic run_division(input int a, input int b);
        while (busy) begin
            @(posedge clock);
            #1;
        end
        dividend = a[DATA_WIDTH-1:0];
        divisor  = b[DATA_WIDTH-1:0];
        predict_result(dividend, divisor);
        valid_in = 1'b1;
        @(posedge clock);
        #1;
        valid_in = 1'b0;
        while (!valid_out) begin
            @(posedge clock);
            #1;
        end
        @(posedge clock);
        #1;
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        fails_at_start = fail_count;
    endtask

    task automatic end_test();
        int test_failures;
        test_failures = fail_count - fails_at_start;
        if (test_failures == 0) begin
            tests_passed++;
            $display("Test %s done, no failures", test_name);
        end else begin
            tests_failed++;
            $display("Test %s done, %0d failures", test_name, test_failures);
        end
    endtask

    initial begin
        logic [31:0]                  rand_word;
        logic signed [DATA_WIDTH-1:0] rand_dividend;
        logic signed [DATA_WIDTH-1:0] rand_divisor;
        clock          = 1'b0;
        reset          = 1'b1;
        valid_in       = 1'b0;
        dividend       = '0;
        divisor        = '0;
        exp_quotient   = '0;
        exp_remainder  = '0;
        exp_status     = '0;
        fail_count     = 0;
        fails_at_start = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        seed           = 32'ha677;

        begin_test("reset");
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        end_test();

        begin_test("signs");
        run_division(25, 3);
        run_division(-25, 3);
        run_division(25, -3);
        run_division(-25, -3);
        run_division(6, 4);
        run_division(-6, 4);
        run_division(6, -4);
        run_division(-6, -4);
        end_test();

        begin_test("div_zero");
        run_division(100, 0);
        run_division(-100, 0);
        run_division(0, 0);
        end_test();

        begin_test("overflow");
        run_division(32767, 1);
        run_division(-32768, 1);
        run_division(32767, -1);
        run_division(-32768, -1); // Most negative over -1
        run_division(200, 1);
        end_test();

        begin_test("random");
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rand_word     = $random(seed);
            rand_dividend = rand_word[DATA_WIDTH-1:0];
            rand_word     = $random(seed);
            rand_divisor  = rand_word[DATA_WIDTH-1:0];
            if (i % 2 == 0) begin
                rand_dividend = rand_dividend >>> QUANTIZED_BITS; // Keeps most in range
            end
            if (i % 5 == 1) begin
                rand_divisor = rand_divisor >>> 10;
            end
            run_division(int'(rand_dividend), int'(rand_divisor));
        end
        end_test();

        $display("Tests: %0d passed, %0d failed, %0d check failures", tests_passed,
                 tests_failed, fail_count);
        if (fail_count == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog: run did not finish within %0d ns, core FSM left in %s",
                 TIMEOUT_NS, core_state.name());
        $display("Simulation failed");
        $finish;
    end

endmodule

/* filelist.f */
source/fixdiv_pkg.sv
source/div_operand_prep.sv
source/nonrestoring_divider.sv
source/div_result_fixup.sv
source/fixdiv_top.sv
tb/fixdiv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

set -o pipefail

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR" && \
verilator --binary --timing --assert -Wno-fatal \
    --top-module fixdiv_tb --Mdir "$BUILD_DIR" -o Vfixdiv_tb \
    -f filelist.f \
    || { echo "Result: build failed"; exit 1; }

"./$BUILD_DIR/Vfixdiv_tb" 2>&1 | tee "$LOG" \
    || { echo "Result: simulator returned an error"; exit 1; }

grep -q "Simulation failed" "$LOG" && { echo "Result: FAIL"; exit 1; }
grep -q "Simulation passed" "$LOG" || { echo "Result: no pass line in $LOG"; exit 1; }

echo "Result: PASS"
exit 0
